//--- rtl/ddr_ctrl_pkg.sv
package ddr_ctrl_pkg;

    // ************************************************************************
    // widths of the DDR2 FIFO interface
    // ************************************************************************

    // DDR2 address width as seen by the af
    localparam int ADDR_W = 31;
    // one write beat on the wdf
    localparam int DATA_W = 128;
    // one mask bit per data byte
    localparam int MASK_W = DATA_W / 8;
    // af command field
    localparam int CMD_W = 3;
    // read tickets, wider than the deepest FIFO so wrap is harmless
    localparam int TICKET_W = 11;

    // af command codes
    localparam logic [CMD_W-1:0] CMD_WRITE = 3'd0;
    localparam logic [CMD_W-1:0] CMD_READ = 3'd1;

    // every read comes back as this many rdf beats
    localparam int BEATS_PER_READ = 2;
    // low bits of the beat counter that index a beat inside one read
    localparam int BEAT_IDX_W = $clog2(BEATS_PER_READ);
    // counter of beats still owed to a cache ticket
    localparam int LEFT_W = $clog2(BEATS_PER_READ + 1);
    // caches that hold read tickets (icache, dcache)
    localparam int N_CACHE = 2;

    // owner of the DDR2 FIFOs for the current cycle
    typedef enum logic [2:0] {
        NONE   = 3'd0,
        ICACHE = 3'd1,
        DCACHE = 3'd2,
        PIXEL  = 3'd3,
        FILLER = 3'd4,
        LINE   = 3'd5
    } client_e;

    // ************************************************************************
    // request bundles, one per kind of client
    // ************************************************************************

    // caches read and write
    typedef struct packed {
        logic [CMD_W-1:0]  cmd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [MASK_W-1:0] mask;
        logic              af_wr;
        logic              wdf_wr;
    } cache_req_t;

    // filler and line engine only write
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [MASK_W-1:0] mask;
        logic              af_wr;
        logic              wdf_wr;
    } wr_req_t;

    // pixel feeder only reads
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              af_wr;
    } rd_req_t;

    // write side of the af and wdf
    typedef struct packed {
        logic [CMD_W-1:0]  cmd;
        logic [ADDR_W-1:0] addr;
        logic              af_wr_en;
        logic [DATA_W-1:0] wdata;
        logic [MASK_W-1:0] mask;
        logic              wdf_wr_en;
    } ddr_wr_t;

    // stall flags back to every client
    typedef struct packed {
        logic icache_af_full;
        logic icache_wdf_full;
        logic dcache_af_full;
        logic dcache_wdf_full;
        logic pixel_af_full;
        logic pixel_wdf_full;
        logic filler_af_full;
        logic filler_wdf_full;
        logic line_af_full;
        logic line_wdf_full;
    } client_full_t;

endpackage

//--- rtl/burst_lock.sv
`timescale 1ns/1ps

module burst_lock (
    input  logic                  clk,
    input  logic                  rst,
    input  ddr_ctrl_pkg::client_e i_grant,
    input  logic                  i_fifo_ready,
    output logic                  o_filler_locked,
    output logic                  o_line_locked
);

    // ************************************************************************
    // mid-burst reservation
    // the filler and the line engine run on their own and push a write as
    // two beats; between them no other client may take the FIFOs or the
    // address and data streams get interleaved
    // ************************************************************************

    // a beat counts only when the client holds the grant and both FIFOs
    // had room, i.e. the strobes really went out
    logic filler_beat;
    logic line_beat;

    assign filler_beat = i_fifo_ready && (i_grant == ddr_ctrl_pkg::FILLER);
    assign line_beat   = i_fifo_ready && (i_grant == ddr_ctrl_pkg::LINE);

    // flag flips on every accepted beat
    // odd beat count -> burst is open -> lock set
    // even beat count -> burst closed -> lock clear
    always_ff @(posedge clk) begin
        if (rst) begin
            o_filler_locked <= 1'b0;
            o_line_locked   <= 1'b0;
        end else begin
            if (filler_beat) begin
                o_filler_locked <= ~o_filler_locked;
            end
            if (line_beat) begin
                o_line_locked <= ~o_line_locked;
            end
        end
    end

    // back-pressure leaves both flags alone since no beat is accepted

endmodule

//--- rtl/priority_arbiter.sv
`timescale 1ns/1ps

module priority_arbiter (
    input  ddr_ctrl_pkg::cache_req_t   i_icache,
    input  ddr_ctrl_pkg::cache_req_t   i_dcache,
    input  ddr_ctrl_pkg::rd_req_t      i_pixel,
    input  ddr_ctrl_pkg::wr_req_t      i_filler,
    input  ddr_ctrl_pkg::wr_req_t      i_line,
    input  logic                       i_af_full,
    input  logic                       i_wdf_full,
    input  logic                       i_filler_locked,
    input  logic                       i_line_locked,
    output ddr_ctrl_pkg::client_e      o_grant,
    output logic                       o_fifo_ready,
    output ddr_ctrl_pkg::ddr_wr_t      o_ddr,
    output ddr_ctrl_pkg::client_full_t o_full
);

    // raw request levels per client
    logic icache_req;
    logic dcache_req;
    logic pixel_req;
    logic filler_req;
    logic line_req;
    // either write burst still open
    logic any_lock;
    // both FIFOs can take a beat
    logic fifo_ready;
    ddr_ctrl_pkg::client_e grant;
    // granted payload before the strobes are gated by FIFO space
    ddr_ctrl_pkg::ddr_wr_t sel;

    // a client wants the FIFOs while it holds any strobe
    assign icache_req = i_icache.af_wr || i_icache.wdf_wr;
    assign dcache_req = i_dcache.af_wr || i_dcache.wdf_wr;
    assign pixel_req  = i_pixel.af_wr;
    assign filler_req = i_filler.af_wr || i_filler.wdf_wr;
    assign line_req   = i_line.af_wr || i_line.wdf_wr;

    assign any_lock   = i_filler_locked || i_line_locked;
    assign fifo_ready = !i_af_full && !i_wdf_full;

    // ************************************************************************
    // fixed priority, icache first and line engine last
    // an open burst shuts out everyone but its owner
    // ************************************************************************

    always_comb begin
        grant = ddr_ctrl_pkg::NONE;
        if (!any_lock && icache_req) begin
            grant = ddr_ctrl_pkg::ICACHE;
        end else if (!any_lock && dcache_req) begin
            grant = ddr_ctrl_pkg::DCACHE;
        end else if (!any_lock && pixel_req) begin
            grant = ddr_ctrl_pkg::PIXEL;
        end else if (!i_line_locked && filler_req) begin
            grant = ddr_ctrl_pkg::FILLER;
        end else if (!i_filler_locked && line_req) begin
            grant = ddr_ctrl_pkg::LINE;
        end
    end

    // ************************************************************************
    // payload mux onto the af and wdf write side
    // ************************************************************************

    always_comb begin
        sel = '0;
        case (grant)
            ddr_ctrl_pkg::ICACHE: begin
                sel.cmd       = i_icache.cmd;
                sel.addr      = i_icache.addr;
                sel.af_wr_en  = i_icache.af_wr;
                sel.wdata     = i_icache.wdata;
                sel.mask      = i_icache.mask;
                sel.wdf_wr_en = i_icache.wdf_wr;
            end
            ddr_ctrl_pkg::DCACHE: begin
                sel.cmd       = i_dcache.cmd;
                sel.addr      = i_dcache.addr;
                sel.af_wr_en  = i_dcache.af_wr;
                sel.wdata     = i_dcache.wdata;
                sel.mask      = i_dcache.mask;
                sel.wdf_wr_en = i_dcache.wdf_wr;
            end
            // pixel reads never touch the wdf
            ddr_ctrl_pkg::PIXEL: begin
                sel.cmd      = ddr_ctrl_pkg::CMD_READ;
                sel.addr     = i_pixel.addr;
                sel.af_wr_en = i_pixel.af_wr;
                sel.mask     = '1;
            end
            ddr_ctrl_pkg::FILLER: begin
                sel.cmd       = ddr_ctrl_pkg::CMD_WRITE;
                sel.addr      = i_filler.addr;
                sel.af_wr_en  = i_filler.af_wr;
                sel.wdata     = i_filler.wdata;
                sel.mask      = i_filler.mask;
                sel.wdf_wr_en = i_filler.wdf_wr;
            end
            ddr_ctrl_pkg::LINE: begin
                sel.cmd       = ddr_ctrl_pkg::CMD_WRITE;
                sel.addr      = i_line.addr;
                sel.af_wr_en  = i_line.af_wr;
                sel.wdata     = i_line.wdata;
                sel.mask      = i_line.mask;
                sel.wdf_wr_en = i_line.wdf_wr;
            end
            default: ;
        endcase
    end

    // strobes only go out while both FIFOs have room
    always_comb begin
        o_ddr           = sel;
        o_ddr.af_wr_en  = sel.af_wr_en && fifo_ready;
        o_ddr.wdf_wr_en = sel.wdf_wr_en && fifo_ready;
    end

    // ************************************************************************
    // stall flags, everyone but the granted client sees full
    // ************************************************************************

    always_comb begin
        o_full = '1;
        case (grant)
            ddr_ctrl_pkg::ICACHE: begin
                o_full.icache_af_full  = !fifo_ready;
                o_full.icache_wdf_full = !fifo_ready;
            end
            ddr_ctrl_pkg::DCACHE: begin
                o_full.dcache_af_full  = !fifo_ready;
                o_full.dcache_wdf_full = !fifo_ready;
            end
            ddr_ctrl_pkg::PIXEL: begin
                o_full.pixel_af_full  = !fifo_ready;
                o_full.pixel_wdf_full = !fifo_ready;
            end
            ddr_ctrl_pkg::FILLER: begin
                o_full.filler_af_full  = !fifo_ready;
                o_full.filler_wdf_full = !fifo_ready;
            end
            ddr_ctrl_pkg::LINE: begin
                o_full.line_af_full  = !fifo_ready;
                o_full.line_wdf_full = !fifo_ready;
            end
            default: ;
        endcase
    end

    // grant and FIFO space feed the burst lock and the read router
    assign o_grant      = grant;
    assign o_fifo_ready = fifo_ready;

endmodule

//--- rtl/read_return_router.sv
`timescale 1ns/1ps

module read_return_router (
    input  logic                                clk,
    input  logic                                rst,
    input  ddr_ctrl_pkg::client_e               i_grant,
    input  logic [ddr_ctrl_pkg::CMD_W-1:0]      i_ddr_cmd,
    input  logic                                i_af_accept,
    input  logic                                i_rdf_valid,
    input  logic                                i_icache_rd_en,
    input  logic                                i_dcache_rd_en,
    input  logic                                i_pixel_rd_en,
    output logic                                o_rdf_rd_en,
    output logic                                o_icache_rdf_valid,
    output logic                                o_dcache_rdf_valid,
    output logic                                o_pixel_rdf_valid
);

    localparam int SRV_W = ddr_ctrl_pkg::TICKET_W + ddr_ctrl_pkg::BEAT_IDX_W;

    // ************************************************************************
    // read bookkeeping
    // the caches do not stream reads, so each one only needs to remember
    // the number of its last read; returns come back in issue order and a
    // running count of popped beats tells whose read is at the rdf head
    // ************************************************************************

    // reads accepted into the af, all clients
    logic [ddr_ctrl_pkg::TICKET_W-1:0] issued_reads;
    // beats popped from the rdf; upper bits are the read number
    logic [SRV_W-1:0]                  serviced_beats;
    logic [ddr_ctrl_pkg::TICKET_W-1:0] serviced_read;
    // a read went into the af this cycle
    logic                              fetch_issued;
    // a beat left the rdf this cycle
    logic                              beat_pop;

    // per cache ticket, index 0 icache, index 1 dcache
    logic [ddr_ctrl_pkg::TICKET_W-1:0] tkt_num  [ddr_ctrl_pkg::N_CACHE];
    logic [ddr_ctrl_pkg::LEFT_W-1:0]   tkt_left [ddr_ctrl_pkg::N_CACHE];
    logic [ddr_ctrl_pkg::N_CACHE-1:0]  tkt_load;
    logic [ddr_ctrl_pkg::N_CACHE-1:0]  tkt_hit;

    assign fetch_issued  = i_af_accept && (i_ddr_cmd == ddr_ctrl_pkg::CMD_READ);
    assign beat_pop      = i_rdf_valid && o_rdf_rd_en;
    assign serviced_read = serviced_beats[SRV_W-1:ddr_ctrl_pkg::BEAT_IDX_W];

    // which cache owns the read being issued
    assign tkt_load[0] = fetch_issued && (i_grant == ddr_ctrl_pkg::ICACHE);
    assign tkt_load[1] = fetch_issued && (i_grant == ddr_ctrl_pkg::DCACHE);

    // ticket still owes beats and its read is at the head of the rdf
    always_comb begin
        for (int c = 0; c < ddr_ctrl_pkg::N_CACHE; c++) begin
            tkt_hit[c] = (tkt_left[c] != '0) && (tkt_num[c] == serviced_read);
        end
    end

    // counters wrap freely, only equality matters
    always_ff @(posedge clk) begin
        if (rst) begin
            issued_reads   <= '0;
            serviced_beats <= '0;
        end else begin
            if (fetch_issued) begin
                issued_reads <= issued_reads + 1'b1;
            end
            if (beat_pop) begin
                serviced_beats <= serviced_beats + 1'b1;
            end
        end
    end

    // load on issue, count down on each popped beat of that read
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < ddr_ctrl_pkg::N_CACHE; c++) begin
                tkt_num[c]  <= '0;
                tkt_left[c] <= '0;
            end
        end else begin
            for (int c = 0; c < ddr_ctrl_pkg::N_CACHE; c++) begin
                if (tkt_load[c]) begin
                    tkt_num[c]  <= issued_reads;
                    tkt_left[c] <= ddr_ctrl_pkg::LEFT_W'(ddr_ctrl_pkg::BEATS_PER_READ);
                end else if (tkt_hit[c] && beat_pop) begin
                    tkt_left[c] <= tkt_left[c] - 1'b1;
                end
            end
        end
    end

    // ************************************************************************
    // return steering, straight from rdf valid
    // ************************************************************************

    // head read belongs to a cache -> that cache pops, else the pixel feeder
    assign o_rdf_rd_en = tkt_hit[0] ? i_icache_rd_en :
                         tkt_hit[1] ? i_dcache_rd_en :
                                      i_pixel_rd_en;

    assign o_icache_rdf_valid = i_rdf_valid && tkt_hit[0];
    assign o_dcache_rdf_valid = i_rdf_valid && tkt_hit[1] && !tkt_hit[0];
    // anything unclaimed is pixel data
    assign o_pixel_rdf_valid  = i_rdf_valid && !(|tkt_hit);

endmodule

//--- rtl/ddr_request_controller.sv
`timescale 1ns/1ps

module ddr_request_controller (
    input  logic                       clk,
    input  logic                       rst,

    // cache requests, read and write
    input  ddr_ctrl_pkg::cache_req_t   i_icache,
    input  ddr_ctrl_pkg::cache_req_t   i_dcache,
    // pixel feeder, read only
    input  ddr_ctrl_pkg::rd_req_t      i_pixel,
    // color filler and line engine, write only
    input  ddr_ctrl_pkg::wr_req_t      i_filler,
    input  ddr_ctrl_pkg::wr_req_t      i_line,

    // DDR2 FIFO status
    input  logic                       i_af_full,
    input  logic                       i_wdf_full,
    input  logic                       i_rdf_valid,

    // rdf pop strobes from the readers
    input  logic                       i_icache_rd_en,
    input  logic                       i_dcache_rd_en,
    input  logic                       i_pixel_rd_en,

    // DDR2 FIFO write side and rdf pop
    output ddr_ctrl_pkg::ddr_wr_t      o_ddr,
    output logic                       o_rdf_rd_en,

    // stall flags per client
    output ddr_ctrl_pkg::client_full_t o_full,

    // read return valids
    output logic                       o_icache_rdf_valid,
    output logic                       o_dcache_rdf_valid,
    output logic                       o_pixel_rdf_valid
);

    ddr_ctrl_pkg::client_e grant;
    logic                  fifo_ready;
    logic                  filler_locked;
    logic                  line_locked;

    // ************************************************************************
    // request side
    // ************************************************************************

    burst_lock u_burst_lock (
        .clk             (clk),
        .rst             (rst),
        .i_grant         (grant),
        .i_fifo_ready    (fifo_ready),
        .o_filler_locked (filler_locked),
        .o_line_locked   (line_locked)
    );

    priority_arbiter u_priority_arbiter (
        .i_icache        (i_icache),
        .i_dcache        (i_dcache),
        .i_pixel         (i_pixel),
        .i_filler        (i_filler),
        .i_line          (i_line),
        .i_af_full       (i_af_full),
        .i_wdf_full      (i_wdf_full),
        .i_filler_locked (filler_locked),
        .i_line_locked   (line_locked),
        .o_grant         (grant),
        .o_fifo_ready    (fifo_ready),
        .o_ddr           (o_ddr),
        .o_full          (o_full)
    );

    // ************************************************************************
    // return side
    // ************************************************************************

    read_return_router u_read_return_router (
        .clk                (clk),
        .rst                (rst),
        .i_grant            (grant),
        .i_ddr_cmd          (o_ddr.cmd),
        .i_af_accept        (o_ddr.af_wr_en),
        .i_rdf_valid        (i_rdf_valid),
        .i_icache_rd_en     (i_icache_rd_en),
        .i_dcache_rd_en     (i_dcache_rd_en),
        .i_pixel_rd_en      (i_pixel_rd_en),
        .o_rdf_rd_en        (o_rdf_rd_en),
        .o_icache_rdf_valid (o_icache_rdf_valid),
        .o_dcache_rdf_valid (o_dcache_rdf_valid),
        .o_pixel_rdf_valid  (o_pixel_rdf_valid)
    );

endmodule

//--- dv/tb_ddr_request_controller.sv
`timescale 1ns/1ps

module tb_ddr_request_controller;

    // ************************************************************************
    // vector replay testbench
    // each record of dv/ddr_stim.txt holds one cycle of inputs and the
    // outputs expected in that same cycle
    // ************************************************************************

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 5;
    // margin on top of the replay length before the run is called hung
    localparam int SLACK_CYCLES = 20;
    // fields per record, eleven hex words on one line
    localparam int N_FIELDS     = 11;
    localparam int MAX_RECORDS  = 256;
    // marks memory words the data file did not fill
    localparam logic [11:0] EMPTY_WORD = 12'heee;
    // compare width, wide enough for one write beat
    localparam int CW = ddr_ctrl_pkg::DATA_W;

    // fixed payload per client so o_ddr shows who was muxed through
    localparam logic [ddr_ctrl_pkg::ADDR_W-1:0] ICACHE_ADDR = 31'h0010_0040;
    localparam logic [ddr_ctrl_pkg::ADDR_W-1:0] DCACHE_ADDR = 31'h0020_0080;
    localparam logic [ddr_ctrl_pkg::ADDR_W-1:0] PIXEL_ADDR  = 31'h0030_00c0;
    localparam logic [ddr_ctrl_pkg::ADDR_W-1:0] FILLER_ADDR = 31'h0040_0100;
    localparam logic [ddr_ctrl_pkg::ADDR_W-1:0] LINE_ADDR   = 31'h0050_0140;
    localparam logic [ddr_ctrl_pkg::DATA_W-1:0] ICACHE_DATA = {4{32'h1ca0_0001}};
    localparam logic [ddr_ctrl_pkg::DATA_W-1:0] DCACHE_DATA = {4{32'hdca0_0002}};
    localparam logic [ddr_ctrl_pkg::DATA_W-1:0] FILLER_DATA = {4{32'hf111_0004}};
    localparam logic [ddr_ctrl_pkg::DATA_W-1:0] LINE_DATA   = {4{32'h11e0_0005}};
    localparam logic [ddr_ctrl_pkg::MASK_W-1:0] ICACHE_MASK = 16'h00ff;
    localparam logic [ddr_ctrl_pkg::MASK_W-1:0] DCACHE_MASK = 16'hff00;
    localparam logic [ddr_ctrl_pkg::MASK_W-1:0] FILLER_MASK = 16'h0f0f;
    localparam logic [ddr_ctrl_pkg::MASK_W-1:0] LINE_MASK   = 16'hf0f0;

    logic clk;
    logic rst;

    // DUT inputs
    ddr_ctrl_pkg::cache_req_t   icache;
    ddr_ctrl_pkg::cache_req_t   dcache;
    ddr_ctrl_pkg::rd_req_t      pixel;
    ddr_ctrl_pkg::wr_req_t      filler;
    ddr_ctrl_pkg::wr_req_t      line;
    logic                       af_full;
    logic                       wdf_full;
    logic                       rdf_valid;
    logic                       icache_rd_en;
    logic                       dcache_rd_en;
    logic                       pixel_rd_en;

    // DUT outputs
    ddr_ctrl_pkg::ddr_wr_t      ddr;
    logic                       rdf_rd_en;
    ddr_ctrl_pkg::client_full_t full;
    logic                       icache_rdf_valid;
    logic                       dcache_rdf_valid;
    logic                       pixel_rdf_valid;

    logic [11:0] vec_mem [MAX_RECORDS*N_FIELDS];
    int          num_records = 0;
    int          cur_record  = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    ddr_request_controller dut (
        .clk                (clk),
        .rst                (rst),
        .i_icache           (icache),
        .i_dcache           (dcache),
        .i_pixel            (pixel),
        .i_filler           (filler),
        .i_line             (line),
        .i_af_full          (af_full),
        .i_wdf_full         (wdf_full),
        .i_rdf_valid        (rdf_valid),
        .i_icache_rd_en     (icache_rd_en),
        .i_dcache_rd_en     (dcache_rd_en),
        .i_pixel_rd_en      (pixel_rd_en),
        .o_ddr              (ddr),
        .o_rdf_rd_en        (rdf_rd_en),
        .o_full             (full),
        .o_icache_rdf_valid (icache_rdf_valid),
        .o_dcache_rdf_valid (dcache_rdf_valid),
        .o_pixel_rdf_valid  (pixel_rdf_valid)
    );

    always #HALF_PERIOD clk = ~clk;

    // hang guard, limit set once the record count is known
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: replay still running after %0d cycles", cycle_limit);
            $display("** FAIL **");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [11:0] record_field(input int r, input int k);
        return vec_mem[r*N_FIELDS + k];
    endfunction

    task automatic check_value(input string name, input logic [CW-1:0] actual,
                               input logic [CW-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h (record %0d)",
                     $time, name, actual, expected, cur_record);
            $display("** FAIL **");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic drive_idle();
        icache       = '0;
        dcache       = '0;
        pixel        = '0;
        filler       = '0;
        line         = '0;
        af_full      = 1'b0;
        wdf_full     = 1'b0;
        rdf_valid    = 1'b0;
        icache_rd_en = 1'b0;
        dcache_rd_en = 1'b0;
        pixel_rd_en  = 1'b0;
    endtask

    // input side of one record onto the DUT ports
    task automatic apply_record(input int r);
        logic [11:0] f_ic;
        logic [11:0] f_dc;
        logic [11:0] f_px;
        logic [11:0] f_fl;
        logic [11:0] f_ln;
        logic [11:0] f_st;
        logic [11:0] f_rd;
        f_ic = record_field(r, 0);
        f_dc = record_field(r, 1);
        f_px = record_field(r, 2);
        f_fl = record_field(r, 3);
        f_ln = record_field(r, 4);
        f_st = record_field(r, 5);
        f_rd = record_field(r, 6);
        // caches: bit 3 picks a read, bits 1 and 0 are the af and wdf strobes
        icache.cmd    = f_ic[3] ? ddr_ctrl_pkg::CMD_READ : ddr_ctrl_pkg::CMD_WRITE;
        icache.addr   = ICACHE_ADDR;
        icache.wdata  = ICACHE_DATA;
        icache.mask   = ICACHE_MASK;
        icache.af_wr  = f_ic[1];
        icache.wdf_wr = f_ic[0];
        dcache.cmd    = f_dc[3] ? ddr_ctrl_pkg::CMD_READ : ddr_ctrl_pkg::CMD_WRITE;
        dcache.addr   = DCACHE_ADDR;
        dcache.wdata  = DCACHE_DATA;
        dcache.mask   = DCACHE_MASK;
        dcache.af_wr  = f_dc[1];
        dcache.wdf_wr = f_dc[0];
        pixel.addr    = PIXEL_ADDR;
        pixel.af_wr   = f_px[0];
        filler.addr   = FILLER_ADDR;
        filler.wdata  = FILLER_DATA;
        filler.mask   = FILLER_MASK;
        filler.af_wr  = f_fl[1];
        filler.wdf_wr = f_fl[0];
        line.addr     = LINE_ADDR;
        line.wdata    = LINE_DATA;
        line.mask     = LINE_MASK;
        line.af_wr    = f_ln[1];
        line.wdf_wr   = f_ln[0];
        af_full       = f_st[2];
        wdf_full      = f_st[1];
        rdf_valid     = f_st[0];
        icache_rd_en  = f_rd[2];
        dcache_rd_en  = f_rd[1];
        pixel_rd_en   = f_rd[0];
    endtask

    // expected side of one record against the settled outputs
    task automatic check_record(input int r);
        logic [11:0]                     f_ic;
        logic [11:0]                     f_dc;
        logic [11:0]                     f_cl;
        logic [11:0]                     f_sb;
        logic [11:0]                     f_full;
        logic [11:0]                     f_rv;
        logic [ddr_ctrl_pkg::CMD_W-1:0]  exp_cmd;
        logic [ddr_ctrl_pkg::ADDR_W-1:0] exp_addr;
        logic [ddr_ctrl_pkg::DATA_W-1:0] exp_data;
        logic [ddr_ctrl_pkg::MASK_W-1:0] exp_mask;
        logic                            has_data;
        f_ic   = record_field(r, 0);
        f_dc   = record_field(r, 1);
        f_cl   = record_field(r, 7);
        f_sb   = record_field(r, 8);
        f_full = record_field(r, 9);
        f_rv   = record_field(r, 10);
        check_value("o_ddr.af_wr_en", CW'(ddr.af_wr_en), CW'(f_sb[1]));
        check_value("o_ddr.wdf_wr_en", CW'(ddr.wdf_wr_en), CW'(f_sb[0]));
        check_value("o_full", CW'(full), CW'(f_full[9:0]));
        check_value("o_rdf_rd_en", CW'(rdf_rd_en), CW'(f_rv[3]));
        check_value("o_icache_rdf_valid", CW'(icache_rdf_valid), CW'(f_rv[2]));
        check_value("o_dcache_rdf_valid", CW'(dcache_rdf_valid), CW'(f_rv[1]));
        check_value("o_pixel_rdf_valid", CW'(pixel_rdf_valid), CW'(f_rv[0]));
        // payload of the granted client, pixel reads carry no data
        exp_cmd  = ddr_ctrl_pkg::CMD_WRITE;
        exp_addr = '0;
        exp_data = '0;
        exp_mask = '0;
        has_data = 1'b1;
        case (f_cl[2:0])
            ddr_ctrl_pkg::ICACHE: begin
                exp_cmd  = f_ic[3] ? ddr_ctrl_pkg::CMD_READ : ddr_ctrl_pkg::CMD_WRITE;
                exp_addr = ICACHE_ADDR;
                exp_data = ICACHE_DATA;
                exp_mask = ICACHE_MASK;
            end
            ddr_ctrl_pkg::DCACHE: begin
                exp_cmd  = f_dc[3] ? ddr_ctrl_pkg::CMD_READ : ddr_ctrl_pkg::CMD_WRITE;
                exp_addr = DCACHE_ADDR;
                exp_data = DCACHE_DATA;
                exp_mask = DCACHE_MASK;
            end
            ddr_ctrl_pkg::PIXEL: begin
                exp_cmd  = ddr_ctrl_pkg::CMD_READ;
                exp_addr = PIXEL_ADDR;
                exp_mask = '1;
                has_data = 1'b0;
            end
            ddr_ctrl_pkg::FILLER: begin
                exp_addr = FILLER_ADDR;
                exp_data = FILLER_DATA;
                exp_mask = FILLER_MASK;
            end
            ddr_ctrl_pkg::LINE: begin
                exp_addr = LINE_ADDR;
                exp_data = LINE_DATA;
                exp_mask = LINE_MASK;
            end
            default: begin
                has_data = 1'b0;
            end
        endcase
        if (f_cl[2:0] != 3'd0) begin
            check_value("o_ddr.cmd", CW'(ddr.cmd), CW'(exp_cmd));
            check_value("o_ddr.addr", CW'(ddr.addr), CW'(exp_addr));
            check_value("o_ddr.mask", CW'(ddr.mask), CW'(exp_mask));
            if (has_data) begin
                check_value("o_ddr.wdata", ddr.wdata, exp_data);
            end
        end
    endtask

    // ************************************************************************
    // main sequence
    // ************************************************************************

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        drive_idle();
        for (int i = 0; i < MAX_RECORDS*N_FIELDS; i++) begin
            vec_mem[i] = EMPTY_WORD;
        end
        $readmemh("dv/ddr_stim.txt", vec_mem);
        // records run until the first unfilled slot
        while (num_records < MAX_RECORDS &&
               record_field(num_records, 0) != EMPTY_WORD) begin
            num_records = num_records + 1;
        end
        if (num_records == 0) begin
            $display("no vectors could be loaded from dv/ddr_stim.txt");
            $display("** FAIL **");
            $fatal(1, "empty vector file");
        end
        cycle_limit = RESET_CYCLES + num_records + SLACK_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < num_records; r++) begin
            if (r != 0) begin
                @(negedge clk);
            end
            cur_record = r;
            apply_record(r);
            // halfway to the next rising edge the comb paths have settled
            #(HALF_PERIOD / 2);
            check_record(r);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

//--- dv/ddr_stim.txt
// in:  ic dc px fl ln st rd  ic/dc 8=read 2=af_wr 1=wdf_wr, px 1=af_wr, fl/ln 2=af_wr 1=wdf_wr
//      st 4=af_full 2=wdf_full 1=rdf_valid, rd 4=icache 2=dcache 1=pixel rd_en
// exp: cl sb full rv  cl=client on o_ddr (0 skips payload), sb 2=af_wr_en 1=wdf_wr_en
//      full=o_full, rv 8=rdf_rd_en 4=icache 2=dcache 1=pixel rdf_valid
// reset state, idle inputs
0 0 0 0 0 0 0   0 0 3FF 0
0 0 0 0 0 0 0   0 0 3FF 0
// priority, all five request then drop the winner each cycle
3 3 1 3 3 0 0   1 3 0FF 0
0 3 1 3 3 0 0   2 3 33F 0
0 0 1 3 3 0 0   3 2 3CF 0
0 0 0 3 3 0 0   4 3 3F3 0
0 0 0 1 3 0 0   4 1 3F3 0
0 0 0 0 3 0 0   5 3 3FC 0
0 3 0 0 1 0 0   5 1 3FC 0
0 3 0 0 0 0 0   2 3 33F 0
0 0 0 0 0 0 0   0 0 3FF 0
// back-pressure, granted client stalls
3 0 0 0 0 4 0   1 0 3FF 0
3 0 0 0 0 2 0   1 0 3FF 0
0 A 0 0 0 6 0   2 0 3FF 0
3 0 0 0 0 0 0   1 3 0FF 0
0 0 0 0 0 0 0   0 0 3FF 0
// filler burst holds off the icache
0 0 0 3 0 0 0   4 3 3F3 0
3 0 0 1 0 0 0   4 1 3F3 0
3 0 0 0 0 0 0   1 3 0FF 0
// filler burst held across a full af
0 0 0 3 0 0 0   4 3 3F3 0
3 3 1 1 0 4 0   4 0 3FF 0
3 3 1 1 0 0 0   4 1 3F3 0
3 0 0 0 0 0 0   1 3 0FF 0
0 0 0 0 0 0 0   0 0 3FF 0
// pixel return of the earlier pixel read, rd_en follows the pixel strobe
0 0 0 0 0 1 1   0 0 3FF 9
0 0 0 0 0 1 0   0 0 3FF 1
0 0 0 0 0 0 1   0 0 3FF 8
0 0 0 0 0 1 1   0 0 3FF 9
0 0 0 0 0 0 0   0 0 3FF 0
// icache read then dcache read behind it
A 0 0 0 0 0 0   1 2 0FF 0
0 A 0 0 0 0 0   2 2 33F 0
0 0 0 0 0 1 4   0 0 3FF C
0 0 0 0 0 0 0   0 0 3FF 0
0 0 0 0 0 1 4   0 0 3FF C
0 0 0 0 0 1 2   0 0 3FF A
0 0 0 0 0 1 2   0 0 3FF A
// tickets retired, stray data falls to the pixel feeder
0 0 0 0 0 1 0   0 0 3FF 1
0 0 0 0 0 0 0   0 0 3FF 0

//--- list.f
rtl/ddr_ctrl_pkg.sv
rtl/burst_lock.sv
rtl/priority_arbiter.sv
rtl/read_return_router.sv
rtl/ddr_request_controller.sv
dv/tb_ddr_request_controller.sv

//--- Makefile
TOP := tb_ddr_request_controller

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): list.f rtl/*.sv dv/*.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f list.f

# exit status of the simulation is the pass or fail result
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
